// File: source/dds_pkg.sv
`default_nettype none

package dds_pkg;

	////////////////////////////////////////////////////////////////////////////
	// widths
	////////////////////////////////////////////////////////////////////////////

	localparam int FRAME_W = 64;                 // longest frame, header plus 48-bit word
	localparam int FREQ_W  = 48;                 // frequency tuning word
	localparam int PHASE_W = 14;                 // phase offset
	localparam int AMP_W   = 10;                 // amplitude scale
	localparam int LEN_W   = 7;                  // frame length field, holds 64
	localparam int ADDR_W  = 8;                  // apb byte address
	localparam int DATA_W  = 32;                 // apb data bus
	localparam int STEP_W  = 32;                 // sweep step
	localparam int COUNT_W = 16;                 // sweep step count

	// serial instruction headers: write flag, length code, register address
	localparam logic [15:0] HDR_FREQ  = {1'b0, 2'd3, 13'h01AB}; // ftw, 6 bytes
	localparam logic [15:0] HDR_PHASE = {1'b0, 2'd1, 13'h01AD}; // pow, 2 bytes
	localparam logic [15:0] HDR_AMP   = {1'b0, 2'd1, 13'h040C}; // asf, 2 bytes

	localparam logic [LEN_W-1:0] LEN_LONG  = 7'd64; // header + 48 bits
	localparam logic [LEN_W-1:0] LEN_SHORT = 7'd32; // header + 16 bits, upper half of frame

	localparam int UPDATE_LATENCY = 5;           // cycles from io_update to done
	localparam int LAT_W          = 3;           // latency counter width

	// apb register map
	localparam logic [ADDR_W-1:0] REG_CTRL    = 8'h00; // write only, self clearing
	localparam logic [ADDR_W-1:0] REG_FREQ_LO = 8'h04;
	localparam logic [ADDR_W-1:0] REG_FREQ_HI = 8'h08;
	localparam logic [ADDR_W-1:0] REG_PHASE   = 8'h0C;
	localparam logic [ADDR_W-1:0] REG_AMP     = 8'h10;
	localparam logic [ADDR_W-1:0] REG_STEP    = 8'h14;
	localparam logic [ADDR_W-1:0] REG_COUNT   = 8'h18;
	localparam logic [ADDR_W-1:0] REG_STATUS  = 8'h1C; // read only

endpackage

`default_nettype wire

// File: source/dds_apb_regs.sv
`default_nettype none

module dds_apb_regs import dds_pkg::*; (
	input  logic                clk_in,
	input  logic                reset_in,
	input  logic                psel,
	input  logic                penable,
	input  logic                pwrite,
	input  logic [ADDR_W-1:0]   paddr,
	input  logic [DATA_W-1:0]   pwdata,
	output logic [DATA_W-1:0]   prdata,
	output logic                pready,
	output logic                pslverr,
	output logic [FREQ_W-1:0]   freq,         // to sweep sequencer
	output logic [STEP_W-1:0]   step,
	output logic [COUNT_W-1:0]  count,
	output logic                sweep_start,  // one cycle pulse
	input  logic                sweep_active,
	input  logic                sweep_done,   // sweep frame completed
	output logic                req,
	output logic [FRAME_W-1:0]  frame,
	output logic [LEN_W-1:0]    len,
	input  logic                done
);

	logic [31:0]          freq_lo;
	logic [15:0]          freq_hi;
	logic [PHASE_W-1:0]   phase_reg;
	logic [AMP_W-1:0]     amp_reg;
	logic [2:0]           pending;            // amp, phase, freq
	logic [1:0]           sel;                // frame in flight
	logic [15:0]          done_cnt;           // wraps
	logic                 addr_hit;
	logic                 wr_en;
	logic                 ctrl_wr;
	logic [2:0]           clr_mask;

	////////////////////////////////////////////////////////////////////////////
	// apb decode
	////////////////////////////////////////////////////////////////////////////

	assign pready   = 1'b1;                   // no wait states
	assign wr_en    = psel && penable && pwrite && addr_hit;
	assign ctrl_wr  = wr_en && (paddr == REG_CTRL);
	assign pslverr  = psel && penable && !addr_hit;
	assign clr_mask = (req && done) ? (3'b001 << sel) : 3'b000;

	always_comb begin
		addr_hit = 1'b1;
		prdata   = '0;                        // ctrl reads zero
		case (paddr)
			REG_CTRL:    prdata = '0;
			REG_FREQ_LO: prdata = freq_lo;
			REG_FREQ_HI: prdata = DATA_W'(freq_hi);
			REG_PHASE:   prdata = DATA_W'(phase_reg);
			REG_AMP:     prdata = DATA_W'(amp_reg);
			REG_STEP:    prdata = step;
			REG_COUNT:   prdata = DATA_W'(count);
			REG_STATUS:  prdata = {done_cnt, 12'd0, sweep_active, pending};
			default:     addr_hit = 1'b0;     // outside the map
		endcase
	end

	// settings registers
	always_ff @(posedge clk_in) begin
		if (reset_in) begin
			freq_lo   <= '0;
			freq_hi   <= '0;
			phase_reg <= '0;
			amp_reg   <= '0;
			step      <= '0;
			count     <= '0;
		end else if (wr_en) begin
			case (paddr)
				REG_FREQ_LO: freq_lo   <= pwdata;
				REG_FREQ_HI: freq_hi   <= pwdata[15:0];
				REG_PHASE:   phase_reg <= pwdata[PHASE_W-1:0];
				REG_AMP:     amp_reg   <= pwdata[AMP_W-1:0];
				REG_STEP:    step      <= pwdata;
				REG_COUNT:   count     <= pwdata[COUNT_W-1:0];
				default:     ;            // ctrl and status handled below
			endcase
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// pending frames and requester handshake
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_in) begin
		if (reset_in) begin
			pending     <= '0;
			sel         <= '0;
			req         <= 1'b0;
			sweep_start <= 1'b0;
			done_cnt    <= '0;
		end else begin
			pending     <= (pending & ~clr_mask) | (ctrl_wr ? pwdata[2:0] : 3'b000); // or in
			sweep_start <= ctrl_wr && pwdata[3];
			if (req) begin
				if (done)
					req <= 1'b0;              // bit cleared via clr_mask
			end else if (pending != 3'b000) begin
				req <= 1'b1;
				sel <= pending[0] ? 2'd0 : (pending[1] ? 2'd1 : 2'd2); // freq first
			end
			if (done || sweep_done)
				done_cnt <= done_cnt + 16'd1;
		end
	end

	// frame built from live values, latched by the transmitter at grant
	always_comb begin
		case (sel)
			2'd0:    frame = {HDR_FREQ, freq_hi, freq_lo};
			2'd1:    frame = {HDR_PHASE, {(16-PHASE_W){1'b0}}, phase_reg, 32'd0};
			default: frame = {HDR_AMP, {(16-AMP_W){1'b0}}, amp_reg, 32'd0};
		endcase
	end

	assign len  = (sel == 2'd0) ? LEN_LONG : LEN_SHORT;
	assign freq = {freq_hi, freq_lo};

endmodule

`default_nettype wire

// File: source/dds_sweep_gen.sv
`default_nettype none

module dds_sweep_gen import dds_pkg::*; (
	input  logic                clk_in,
	input  logic                reset_in,
	input  logic [FREQ_W-1:0]   freq,         // start frequency F
	input  logic [STEP_W-1:0]   step,         // step S
	input  logic [COUNT_W-1:0]  count,        // number of steps N
	input  logic                sweep_start,
	output logic                sweep_active,
	output logic                req,
	output logic [FRAME_W-1:0]  frame,
	output logic [LEN_W-1:0]    len,
	input  logic                done
);

	logic [FREQ_W-1:0]   run_freq;            // F + k*S, wraps at 2^48
	logic [STEP_W-1:0]   step_reg;
	logic [COUNT_W-1:0]  remain;              // frames still owed
	logic                load;
	logic                advance;

	////////////////////////////////////////////////////////////////////////////
	// sequencing
	////////////////////////////////////////////////////////////////////////////

	assign load    = sweep_start && !sweep_active;  // start while active ignored
	assign advance = sweep_active && !req;          // add step, then request

	always_ff @(posedge clk_in) begin
		if (reset_in) begin
			sweep_active <= 1'b0;
			req          <= 1'b0;
			remain       <= '0;
		end else begin
			if (load) begin
				remain       <= count;
				sweep_active <= (count != '0);      // zero count sends nothing
			end else if (advance) begin
				req <= 1'b1;
			end else if (req && done) begin
				req    <= 1'b0;                     // may rerequest next cycle
				remain <= remain - 1'b1;
				if (remain == COUNT_W'(1))
					sweep_active <= 1'b0;           // n-th done ends the run
			end
		end
	end

	// running frequency and latched step
	always_ff @(posedge clk_in) begin
		if (load) begin
			run_freq <= freq;
			step_reg <= step;
		end else if (advance) begin
			run_freq <= run_freq + FREQ_W'(step_reg); // zero extended step
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// frame out
	////////////////////////////////////////////////////////////////////////////

	assign frame = {HDR_FREQ, run_freq};      // always a long frame
	assign len   = LEN_LONG;

endmodule

`default_nettype wire

// File: source/dds_frame_arbiter.sv
`default_nettype none

module dds_frame_arbiter import dds_pkg::*; (
	input  logic                clk_in,
	input  logic                reset_in,
	input  logic                req_a,        // register block
	input  logic [FRAME_W-1:0]  frame_a,
	input  logic [LEN_W-1:0]    len_a,
	output logic                done_a,
	input  logic                req_b,        // sweep sequencer
	input  logic [FRAME_W-1:0]  frame_b,
	input  logic [LEN_W-1:0]    len_b,
	output logic                done_b,
	output logic                tx_start,
	output logic [FRAME_W-1:0]  tx_frame,
	output logic [LEN_W-1:0]    tx_len,
	input  logic                tx_done
);

	logic  granted;                           // transmitter owned for a frame
	logic  owner;                             // 0 = a, 1 = b
	logic  last_b;                            // b served last
	logic  pick_b;

	// round robin, the one not served last wins a tie
	assign pick_b = req_b && (!req_a || !last_b);

	always_ff @(posedge clk_in) begin
		if (reset_in) begin
			granted  <= 1'b0;
			owner    <= 1'b0;
			last_b   <= 1'b1;                 // a first after reset
			tx_start <= 1'b0;
		end else begin
			tx_start <= 1'b0;
			if (!granted) begin
				if (req_a || req_b) begin
					granted  <= 1'b1;
					owner    <= pick_b;
					last_b   <= pick_b;
					tx_start <= 1'b1;         // one cycle, transmitter idle
				end
			end else if (tx_done) begin
				granted <= 1'b0;              // free next cycle
			end
		end
	end

	// requester holds frame and len until done
	assign tx_frame = owner ? frame_b : frame_a;
	assign tx_len   = owner ? len_b : len_a;

	assign done_a = granted && tx_done && !owner;
	assign done_b = granted && tx_done && owner;

endmodule

`default_nettype wire

// File: source/dds_serial_tx.sv
`default_nettype none

module dds_serial_tx import dds_pkg::*; (
	input  logic                clk_in,
	input  logic                reset_in,
	input  logic                start,        // one cycle, only when idle
	input  logic [FRAME_W-1:0]  frame,        // msb first
	input  logic [LEN_W-1:0]    len,          // bits to send
	output logic                done,
	output logic                sclk,
	output logic                csb,
	output logic                sdio,
	output logic                io_update
);

	typedef enum logic [2:0] {
		ST_IDLE,                              // wait for start
		ST_SHIFT,                             // csb low, clocking bits
		ST_UPDATE,                            // csb high, io_update next
		ST_WAIT,                              // update latency
		ST_DONE                               // done pulse
	} state_t;

	state_t               state;
	logic [FRAME_W-1:0]   shift_reg;
	logic [LEN_W-1:0]     bit_cnt;            // bits left incl. current
	logic                 sclk_ph;            // 0 = low half, 1 = high half
	logic [LAT_W-1:0]     lat_cnt;

	assign sclk = sclk_ph;                    // half the system clock

	////////////////////////////////////////////////////////////////////////////
	// control FSM
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_in) begin
		if (reset_in) begin
			state     <= ST_IDLE;
			csb       <= 1'b1;
			sclk_ph   <= 1'b0;
			sdio      <= 1'b0;
			io_update <= 1'b0;
			done      <= 1'b0;
			bit_cnt   <= '0;
			lat_cnt   <= '0;
		end else begin
			case (state)
				ST_IDLE: begin
					if (start) begin
						state   <= ST_SHIFT;
						csb     <= 1'b0;      // falls the cycle after start
						sclk_ph <= 1'b0;
						sdio    <= frame[FRAME_W-1];
						bit_cnt <= len;
					end
				end
				ST_SHIFT: begin
					if (!sclk_ph) begin
						sclk_ph <= 1'b1;      // chip samples on this rise
					end else begin
						sclk_ph <= 1'b0;
						if (bit_cnt == LEN_W'(1)) begin
							csb   <= 1'b1;    // last bit sent
							sdio  <= 1'b0;
							state <= ST_UPDATE;
						end else begin
							sdio    <= shift_reg[FRAME_W-2]; // change while sclk low
							bit_cnt <= bit_cnt - 1'b1;
						end
					end
				end
				ST_UPDATE: begin
					io_update <= 1'b1;
					lat_cnt   <= LAT_W'(UPDATE_LATENCY - 1);
					state     <= ST_WAIT;
				end
				ST_WAIT: begin
					io_update <= 1'b0;
					if (lat_cnt == '0) begin
						done  <= 1'b1;        // UPDATE_LATENCY after io_update
						state <= ST_DONE;
					end else begin
						lat_cnt <= lat_cnt - 1'b1;
					end
				end
				ST_DONE: begin
					done  <= 1'b0;
					state <= ST_IDLE;
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	// shift register, loaded at grant
	always_ff @(posedge clk_in) begin
		if (state == ST_IDLE && start)
			shift_reg <= frame;
		else if (state == ST_SHIFT && sclk_ph)
			shift_reg <= shift_reg << 1;
	end

endmodule

`default_nettype wire

// File: source/dds_subsystem.sv
`default_nettype none

module dds_subsystem import dds_pkg::*; (
	input  logic                clk_in,
	input  logic                reset_in,
	input  logic                psel,
	input  logic                penable,
	input  logic                pwrite,
	input  logic [ADDR_W-1:0]   paddr,
	input  logic [DATA_W-1:0]   pwdata,
	output logic [DATA_W-1:0]   prdata,
	output logic                pready,
	output logic                pslverr,
	output logic                sclk,         // serial port to the chip
	output logic                csb,
	output logic                sdio,
	output logic                io_update
);

	////////////////////////////////////////////////////////////////////////////
	// interconnect
	////////////////////////////////////////////////////////////////////////////

	logic [FREQ_W-1:0]   freq;
	logic [STEP_W-1:0]   step;
	logic [COUNT_W-1:0]  count;
	logic                sweep_start, sweep_active;
	logic                req_a, done_a, req_b, done_b; // a = registers, b = sweep
	logic [FRAME_W-1:0]  frame_a, frame_b, tx_frame;
	logic [LEN_W-1:0]    len_a, len_b, tx_len;
	logic                tx_start, tx_done;

	dds_apb_regs u_regs (
		.clk_in, .reset_in, .psel, .penable, .pwrite, .paddr, .pwdata,
		.prdata, .pready, .pslverr, .freq, .step, .count, .sweep_start,
		.sweep_active, .sweep_done(done_b),   // counted in status
		.req(req_a), .frame(frame_a), .len(len_a), .done(done_a)
	);

	dds_sweep_gen u_sweep (
		.clk_in, .reset_in, .freq, .step, .count, .sweep_start, .sweep_active,
		.req(req_b), .frame(frame_b), .len(len_b), .done(done_b)
	);

	dds_frame_arbiter u_arb (
		.clk_in, .reset_in,
		.req_a, .frame_a, .len_a, .done_a,
		.req_b, .frame_b, .len_b, .done_b,
		.tx_start, .tx_frame, .tx_len, .tx_done
	);

	dds_serial_tx u_tx (
		.clk_in, .reset_in, .start(tx_start), .frame(tx_frame), .len(tx_len),
		.done(tx_done), .sclk, .csb, .sdio, .io_update
	);

endmodule

`default_nettype wire

// File: tests/dds_subsystem_sva.sv
`default_nettype none

module dds_subsystem_sva import dds_pkg::*; (
	input  logic  clk_in,
	input  logic  reset_in,
	input  logic  sclk,
	input  logic  csb,
	input  logic  io_update,
	input  logic  done
);
	timeunit 1ns;
	timeprecision 100ps;

	int fail_cnt = 0;                         // assertion failures so far

	// serial clock parked low between frames
	assert property (@(posedge clk_in) disable iff (reset_in) csb |-> !sclk)
		else begin
			fail_cnt++;
			$error("sclk high while csb is high");
		end

	// update strobe only after chip select released
	assert property (@(posedge clk_in) disable iff (reset_in) $rose(io_update) |-> csb)
		else begin
			fail_cnt++;
			$error("io_update rose during a frame");
		end

	assert property (@(posedge clk_in) disable iff (reset_in)
		$rose(io_update) |-> ##UPDATE_LATENCY done)
		else begin
			fail_cnt++;
			$error("done missing after the update latency");
		end

	// and never earlier than that
	assert property (@(posedge clk_in) disable iff (reset_in)
		done |-> $past(io_update, UPDATE_LATENCY))
		else begin
			fail_cnt++;
			$error("done without io_update the update latency before");
		end

endmodule

bind dds_serial_tx dds_subsystem_sva serial_checks (
	.clk_in(clk_in), .reset_in(reset_in), .sclk(sclk), .csb(csb),
	.io_update(io_update), .done(done)
);

`default_nettype wire

// File: tests/dds_subsystem_tb.sv
`default_nettype none

module dds_subsystem_tb import dds_pkg::*; ();
	timeunit 1ns;
	timeprecision 100ps;

	localparam int QUIET_CYCLES = 300;          // idle time before frames are compared
	localparam int FRAME_CYCLES = 150;          // 136 plus arbitration slack

	logic                clk_in = 1'b0;
	logic                reset_in = 1'b1;
	logic                psel, penable, pwrite;
	logic [ADDR_W-1:0]   paddr;
	logic [DATA_W-1:0]   pwdata, prdata;
	logic                pready, pslverr;
	logic                sclk, csb, sdio, io_update;

	byte                 op_q[$];               // one entry per pattern line
	logic [63:0]         a_q[$], b_q[$], c_q[$];
	logic [FRAME_W-1:0]  exp_q[$], cap_q[$];
	int                  cap_len_q[$];
	logic [FRAME_W-1:0]  shift = '0;
	int                  bits = 0;
	int                  cap_total = 0;
	int                  io_cnt = 0;
	int                  val_errs = 0;
	int                  frame_errs = 0;
	int                  other_errs = 0;
	int                  assert_errs = 0;
	int                  limit_cycles = 0;

	dds_subsystem dds_subsystem_inst (
		.clk_in, .reset_in, .psel, .penable, .pwrite, .paddr, .pwdata,
		.prdata, .pready, .pslverr, .sclk, .csb, .sdio, .io_update
	);

	always #2 clk_in = ~clk_in;                 // 4 ns period

	////////////////////////////////////////////////////////////////////////////
	// serial monitor
	////////////////////////////////////////////////////////////////////////////

	always @(posedge clk_in) begin
		if (!csb && sclk) begin                 // sclk high for one cycle per bit
			shift = {shift[FRAME_W-2:0], sdio};
			bits++;
		end
		if (csb && bits != 0) begin             // frame complete once csb is released
			cap_q.push_back(shift << (FRAME_W - bits)); // left aligned like the frame word
			cap_len_q.push_back(bits);
			cap_total++;
			if (source_of(cap_q[$]) > 2) begin
				other_errs++;
				$display("frame at %0t has an unknown register address", $time);
			end
			bits = 0;
		end
		if (io_update) begin
			io_cnt++;
			if (!csb) begin
				other_errs++;
				$display("io_update high at %0t while csb is low", $time);
			end
		end
	end

	function automatic int source_of(input logic [FRAME_W-1:0] f);
		case (f[60:48])                          // 13-bit register address
			HDR_FREQ[12:0]:  return 0;
			HDR_PHASE[12:0]: return 1;
			HDR_AMP[12:0]:   return 2;
			default:         return 3;
		endcase
	endfunction

	// length code 3 carries the 48-bit word and others a 16-bit field in the upper half
	function automatic logic [FRAME_W-1:0] expected_frame(input logic [15:0] hdr,
			input logic [47:0] pay);
		if (hdr[14:13] == 2'd3)
			return {hdr, pay};
		return {hdr, pay[15:0], 32'd0};
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// compare tasks
	////////////////////////////////////////////////////////////////////////////

	task automatic check_word(input string name, input logic [DATA_W-1:0] got,
			input logic [DATA_W-1:0] exp);
		if (got !== exp) begin
			val_errs++;
			$display("ERROR t=%0t %s: got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_frame(input string name, input logic [FRAME_W-1:0] got,
			input logic [FRAME_W-1:0] exp);
		if (got !== exp) begin
			frame_errs++;
			$display("ERROR t=%0t %s: got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			val_errs++;
			$display("ERROR t=%0t %s: got %b expected %b", $time, name, got, exp);
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// apb master
	////////////////////////////////////////////////////////////////////////////

	task automatic apb_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
		@(posedge clk_in);
		psel    <= 1'b1;                        // setup phase
		penable <= 1'b0;
		pwrite  <= 1'b1;
		paddr   <= addr;
		pwdata  <= data;
		@(posedge clk_in);
		penable <= 1'b1;                        // access phase with pready tied high
		@(posedge clk_in);
		psel    <= 1'b0;
		penable <= 1'b0;
		pwrite  <= 1'b0;
	endtask

	task automatic apb_read(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] exp_data,
			input logic exp_err);
		logic [DATA_W-1:0] got;
		logic              err;
		logic              rdy;
		@(posedge clk_in);
		psel    <= 1'b1;
		penable <= 1'b0;
		pwrite  <= 1'b0;
		paddr   <= addr;
		@(posedge clk_in);
		penable <= 1'b1;
		@(negedge clk_in);                      // outputs settled mid access phase
		got = prdata;
		err = pslverr;
		rdy = pready;
		@(posedge clk_in);
		psel    <= 1'b0;
		penable <= 1'b0;
		check_word($sformatf("prdata @%02h", addr), got, exp_data);
		check_flag($sformatf("pslverr @%02h", addr), err, exp_err);
		check_flag("pready", rdy, 1'b1);
	endtask

	// wait for all expected frames and a quiet port before matching them up
	task automatic settle_and_compare(input bit per_source);
		int ci;
		int ei;
		int src;
		while (cap_q.size() < exp_q.size())
			@(posedge clk_in);
		repeat (QUIET_CYCLES) @(posedge clk_in);
		for (src = 0; src < (per_source ? 3 : 1); src++) begin
			ci = 0;
			for (ei = 0; ei < exp_q.size(); ei++) begin
				if (!per_source || source_of(exp_q[ei]) == src) begin
					while (ci < cap_q.size() && per_source && source_of(cap_q[ci]) != src)
						ci++;
					if (ci < cap_q.size()) begin
						check_frame($sformatf("sdio frame %0d", ei), cap_q[ci], exp_q[ei]);
						check_word("frame bits", DATA_W'(cap_len_q[ci]),
							(exp_q[ei][62:61] == 2'd3) ? DATA_W'(LEN_LONG) : DATA_W'(LEN_SHORT));
						ci++;
					end else begin
						other_errs++;
						$display("expected frame %h never appeared on sdio", exp_q[ei]);
					end
				end
			end
			for (; ci < cap_q.size(); ci++) begin
				if (!per_source || source_of(cap_q[ci]) == src) begin
					other_errs++;
					$display("unexpected frame %h on sdio", cap_q[ci]);
				end
			end
		end
		check_word("io_update pulses", DATA_W'(io_cnt), DATA_W'(cap_total)); // one per frame
		exp_q.delete();
		cap_q.delete();
		cap_len_q.delete();
	endtask

	////////////////////////////////////////////////////////////////////////////
	// pattern playback
	////////////////////////////////////////////////////////////////////////////

	initial begin
		int          fd;
		int          n_frames;
		int          n_idle;
		string       line;
		logic [63:0] a, b, c;
		psel     = 1'b0;
		penable  = 1'b0;
		pwrite   = 1'b0;
		paddr    = '0;
		pwdata   = '0;
		n_frames = 0;
		n_idle   = 0;
		fd = $fopen("tests/dds_patterns.txt", "r");
		if (fd == 0) begin
			other_errs++;
			$display("could not open the pattern file");
		end else begin
			while ($fgets(line, fd) > 0) begin
				if (line.len() > 1 && line.getc(0) != "#") begin
					a = '0;
					b = '0;
					c = '0;
					void'($sscanf(line.substr(1, line.len() - 1), "%h %h %h", a, b, c));
					op_q.push_back(line.getc(0));
					a_q.push_back(a);
					b_q.push_back(b);
					c_q.push_back(c);
					n_frames += (line.getc(0) == "F");
					n_idle   += (line.getc(0) == "I");
				end
			end
			$fclose(fd);
		end
		limit_cycles = 216 + n_frames * FRAME_CYCLES + op_q.size() * 8 + n_idle * QUIET_CYCLES;

		repeat (16) @(posedge clk_in);
		reset_in <= 1'b0;
		foreach (op_q[i]) begin
			case (op_q[i])
				"W": apb_write(a_q[i][ADDR_W-1:0], b_q[i][DATA_W-1:0]);
				"R": apb_read(a_q[i][ADDR_W-1:0], b_q[i][DATA_W-1:0], c_q[i][0]);
				"F": exp_q.push_back(expected_frame(a_q[i][15:0], b_q[i][47:0]));
				"I": settle_and_compare(c_q[i][0]);
				default: begin
					other_errs++;
					$display("pattern line %0d has an unknown operation", i);
				end
			endcase
		end
		repeat (4) @(posedge clk_in);
		assert_errs = dds_subsystem_inst.u_tx.serial_checks.fail_cnt;
		$display("errors: %0d value, %0d frame, %0d other, %0d assertion",
			val_errs, frame_errs, other_errs, assert_errs);
		if (val_errs + frame_errs + other_errs + assert_errs == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

	// watchdog sized once the patterns are loaded
	initial begin
		wait (limit_cycles > 0);
		repeat (limit_cycles) @(posedge clk_in);
		$display("timeout after %0d cycles, frames or transfers did not complete", limit_cycles);
		$display("Regression failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: dds_subsystem.f
source/dds_pkg.sv
source/dds_apb_regs.sv
source/dds_sweep_gen.sv
source/dds_frame_arbiter.sv
source/dds_serial_tx.sv
source/dds_subsystem.sv
tests/dds_subsystem_sva.sv
tests/dds_subsystem_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# builds the dds subsystem testbench with Verilator, runs it and checks the log
set -u

cd "$(dirname "$0")" || exit 1

BUILD_DIR=build
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
	--top-module dds_subsystem_tb -f dds_subsystem.f -Mdir "$BUILD_DIR" -o sim
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

"./$BUILD_DIR/sim" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
	echo "simulation exited with status $sim_status"
	exit 1
fi

if grep -q "^Regression passed$" "$LOG"; then
	exit 0
fi
echo "pass line not found in $LOG"
exit 1

// File: tests/dds_patterns.txt
# op  addr/header  data/payload  flag   (all hex)
# W write, R read (flag = pslverr), F expected frame, I wait for frames (flag 1 = per source order)
R 1c 00000000 0
W 04 ffffe000 0
W 08 fedcffff 0
W 0c ffffffff 0
W 10 ffffffff 0
W 14 00001000 0
W 18 00030003 0
R 08 0000ffff 0
R 0c 00003fff 0
R 10 000003ff 0
R 18 00000003 0
R 00 00000000 0
R 24 00000000 1
W 00 00000007 0
F 61ab ffffffffe000 0
F 21ad 3fff 0
F 240c 03ff 0
I 0 0 0
R 1c 00030000 0
W 00 00000008 0
R 1c 00030008 0
F 61ab fffffffff000 0
F 61ab 000000000000 0
F 61ab 000000001000 0
I 0 0 0
R 1c 00060000 0
W 14 00000100 0
W 18 00000002 0
W 00 0000000e 0
F 21ad 3fff 0
F 240c 03ff 0
F 61ab ffffffffe100 0
F 61ab ffffffffe200 0
I 0 0 1
R 1c 000a0000 0
W 18 00000000 0
W 00 00000008 0
I 0 0 0
R 1c 000a0000 0
